// ==== imageProcessor.sv ====
`timescale 1ns/1ps

module imageProcessor
    import videoPkg::*;
#(
    // Measurement window in clock cycles, one second at 25 MHz
    parameter int WindowTicks = 25000000
) (
    input  logic       iClk,
    input  logic       rstN,
    input  videoT      videoIn,
    input  logic [4:0] debugCtrl,
    output videoT      videoOut,
    output debugWordT  debugOut
);

    // Control word fields
    optionSelT optionSel;
    debugSelT  debugSel;

    // Measurements from the meter
    debugWordT resolution;
    debugWordT frameRate;

    assign optionSel = debugCtrl[2:0];
    assign debugSel  = debugCtrl[4:3];

    // Stream statistics from the sync levels
    videoStatsMeter #(
        .WindowTicks (WindowTicks)
    ) uStatsMeter (
        .iClk       (iClk),
        .rstN       (rstN),
        .sync       (videoIn.sync),
        .resolution (resolution),
        .frameRate  (frameRate)
    );

    // Pixel path, one cycle latency
    pixelOptionBank uOptionBank (
        .iClk     (iClk),
        .rstN     (rstN),
        .videoIn  (videoIn),
        .option   (optionSel),
        .videoOut (videoOut)
    );

    // Debug source mux
    // Combinational so the word follows debugCtrl in the same cycle
    always_comb begin
        case (debugSel)
            2'd0:    debugOut = resolution;
            2'd1:    debugOut = frameRate;
            // Echo of the active operation
            2'd2:    debugOut = debugWordT'(optionSel);
            default: debugOut = '0;
        endcase
    end

endmodule

// ==== list.f ====
+incdir+.
videoPkg.sv
videoStatsMeter.sv
pixelOptionBank.sv
imageProcessor.sv
tbImageProcessor.sv

// ==== pixelOptionBank.sv ====
`timescale 1ns/1ps

module pixelOptionBank
    import videoPkg::*;
(
    input  logic      iClk,
    input  logic      rstN,
    input  videoT     videoIn,
    input  optionSelT option,
    output videoT     videoOut
);

    // Input channels
    logic [7:0] inR;
    logic [7:0] inG;
    logic [7:0] inB;

    // Luma estimate, (r + 2g + b) / 4
    logic [9:0] lumaSum;
    logic [7:0] gray;

    // Candidate results
    pixelT grayPix;
    pixelT invertPix;
    pixelT thresholdPix;
    pixelT redOnlyPix;
    pixelT swapPix;
    pixelT halfPix;
    pixelT selPix;

    assign inR = videoIn.pixel.r;
    assign inG = videoIn.pixel.g;
    assign inB = videoIn.pixel.b;

    // Ten bits hold 255 + 510 + 255
    assign lumaSum = {2'b00, inR} + {1'b0, inG, 1'b0} + {2'b00, inB};
    assign gray    = lumaSum[9:2];

    assign grayPix = '{r: gray, g: gray, b: gray};

    // 255 minus x is the bitwise complement
    assign invertPix = '{r: ~inR, g: ~inG, b: ~inB};

    always_comb begin
        if (gray >= ThresholdLevel) begin
            thresholdPix = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};
        end else begin
            thresholdPix = '0;
        end
    end

    assign redOnlyPix = '{r: inR, g: 8'h00, b: 8'h00};
    assign swapPix    = '{r: inB, g: inG, b: inR};
    assign halfPix    = '{r: inR >> 1, g: inG >> 1, b: inB >> 1};

    // Operation mux
    always_comb begin
        selPix = videoIn.pixel;
        case (optionCodeT'(option))
            optPass:      selPix = videoIn.pixel;
            optGray:      selPix = grayPix;
            optInvert:    selPix = invertPix;
            optThreshold: selPix = thresholdPix;
            optRedOnly:   selPix = redOnlyPix;
            optSwapRB:    selPix = swapPix;
            optHalf:      selPix = halfPix;
            // Black frame but syncs still pass
            optBlack:     selPix = '0;
            default:      selPix = videoIn.pixel;
        endcase
    end

    // One cycle of latency for pixel and syncs alike
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            videoOut <= '0;
        end else begin
            videoOut.pixel <= selPix;
            videoOut.sync  <= videoIn.sync;
        end
    end

    // Syncs leave exactly one cycle after they came in
    syncDelayCheck: assert property (
        @(posedge iClk) disable iff (!rstN)
        $past(rstN) |-> (videoOut.sync == $past(videoIn.sync))
    );

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build and run the image processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --assert -Wno-fatal \
    --top-module tbImageProcessor \
    -f list.f \
    -Mdir obj_dir -o simv > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

# Exit status of the simulation is not used, the log decides
./obj_dir/simv > sim.log 2>&1 || true

grep -q "Verification passed" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { cat sim.log; echo "Simulation failed"; exit 1; }

// ==== tbTasks.svh ====
// Random pixels per option in the pixel path test
localparam int PixelsPerOption = 6;

// Reference model of one pixel operation
function automatic pixelT expectPixel(input logic [2:0] opt, input pixelT p);
    int    luma;
    pixelT q;
    luma = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
    q    = p;
    case (optionCodeT'(opt))
        optGray:      q = '{r: 8'(luma), g: 8'(luma), b: 8'(luma)};
        optInvert:    q = '{r: 8'(255 - int'(p.r)), g: 8'(255 - int'(p.g)),
                            b: 8'(255 - int'(p.b))};
        optThreshold: begin
            if (luma >= int'(ThresholdLevel)) begin
                q = '{r: 8'd255, g: 8'd255, b: 8'd255};
            end else begin
                q = '0;
            end
        end
        optRedOnly:   q = '{r: p.r, g: 8'd0, b: 8'd0};
        optSwapRB:    q = '{r: p.b, g: p.g, b: p.r};
        optHalf:      q = '{r: p.r / 2, g: p.g / 2, b: p.b / 2};
        optBlack:     q = '0;
        default:      q = p;
    endcase
    return q;
endfunction

task automatic randomPixel(output pixelT p);
    logic [31:0] bits;
    randomBits(24, bits);
    p = pixelT'(bits[23:0]);
endtask

// Blank stream, all syncs low
task automatic driveIdle(input int cycles);
    repeat (cycles) begin
        @(negedge iClk);
        videoIn = '0;
    end
endtask

// Frame of equal lines, each led by a blanking gap, plus a trailing gap
task automatic driveFrame(input int lines, input int width, input int gap);
    pixelT pix;
    for (int l = 0; l <= lines; l++) begin
        repeat (gap) begin
            @(negedge iClk);
            videoIn.pixel = '0;
            videoIn.sync  = '{hSync: 1'b1, vSync: 1'b0, lineValid: 1'b0, frameValid: 1'b1};
        end
        if (l < lines) begin
            repeat (width) begin
                @(negedge iClk);
                randomPixel(pix);
                videoIn.pixel = pix;
                videoIn.sync  = '{hSync: 1'b0, vSync: 1'b0, lineValid: 1'b1, frameValid: 1'b1};
            end
        end
    end
    // vSync pulse once the frame is over
    @(negedge iClk);
    videoIn      = '0;
    videoIn.sync = '{hSync: 1'b0, vSync: 1'b1, lineValid: 1'b0, frameValid: 1'b0};
endtask

task automatic checkResetState();
    checkValue("videoOut", 32'(videoOut), 32'd0);
    for (int sel = 0; sel < 4; sel++) begin
        @(negedge iClk);
        debugCtrl = {2'(sel), 3'd0};
        #1;
        checkValue("debugOut", 32'(debugOut), 32'd0);
        checkValue("videoOut", 32'(videoOut), 32'd0);
    end
endtask

// Random pixels and syncs, result expected one cycle later
task automatic checkOptions();
    videoT       expected;
    logic        havePrev;
    logic [31:0] bits;
    pixelT       pix;
    for (int opt = 0; opt < 8; opt++) begin
        havePrev = 1'b0;
        for (int i = 0; i <= PixelsPerOption; i++) begin
            @(negedge iClk);
            if (havePrev) begin
                checkValue("videoOut", 32'(videoOut), 32'(expected));
            end
            if (i < PixelsPerOption) begin
                randomPixel(pix);
                randomBits(4, bits);
                videoIn.pixel  = pix;
                videoIn.sync   = syncT'(bits[3:0]);
                debugCtrl      = {2'd0, 3'(opt)};
                expected.pixel = expectPixel(3'(opt), pix);
                expected.sync  = videoIn.sync;
                havePrev       = 1'b1;
            end
        end
    end
    driveIdle(4);
endtask

task automatic checkResolution();
    driveFrame(5, 12, 4);
    driveIdle(3);
    debugCtrl = {2'd0, 3'd0};
    #1;
    checkValue("debugOut", 32'(debugOut), 32'({12'd12, 12'd5}));
    driveFrame(3, 7, 3);
    driveIdle(3);
    #1;
    checkValue("debugOut", 32'(debugOut), 32'({12'd7, 12'd3}));
endtask

task automatic checkFrameRate();
    int windowEnd;
    // Skip to a fresh window so earlier frames do not count
    windowEnd = ((ticksSinceReset / WindowTicks) + 1) * WindowTicks;
    while (ticksSinceReset < windowEnd) @(negedge iClk);
    windowEnd = windowEnd + WindowTicks;
    repeat (3) begin
        driveFrame(2, 3, 2);
        driveIdle(2);
    end
    if (ticksSinceReset >= windowEnd) begin
        $display("Frame rate test: the three frames did not fit in one window");
        failRun();
    end
    while (ticksSinceReset < windowEnd) @(negedge iClk);
    debugCtrl = {2'd1, 3'd0};
    #1;
    checkValue("debugOut", 32'(debugOut), 32'd3);
endtask

// Select 2 echoes the option, select 3 reads zero, both without delay
task automatic checkDebugSelect();
    for (int opt = 0; opt < 8; opt++) begin
        @(negedge iClk);
        debugCtrl = {2'd2, 3'(opt)};
        #1;
        checkValue("debugOut", 32'(debugOut), 32'(opt));
    end
    @(negedge iClk);
    debugCtrl = {2'd3, 3'd5};
    #1;
    checkValue("debugOut", 32'(debugOut), 32'd0);
endtask

// ==== tbImageProcessor.sv ====
`timescale 1ns/1ps

module tbImageProcessor
    import videoPkg::*;
();

    localparam int ClockPeriod   = 4;
    localparam int ResetCycles   = 8;
    localparam int WindowTicks   = 400;
    // Tests need roughly 900 cycles, two FPS windows included
    localparam int TimeoutCycles = 3000;

    // DUT ports
    logic       iClk;
    logic       rstN;
    videoT      videoIn;
    logic [4:0] debugCtrl;
    videoT      videoOut;
    debugWordT  debugOut;

    // Random source state
    logic [31:0] lfsrState = 32'h7c85;

    // Free running count for the timeout
    int cycleCount = 0;
    // Rising edges since reset release, mirrors the DUT window timer
    int ticksSinceReset = 0;

    imageProcessor #(
        .WindowTicks (WindowTicks)
    ) i_imageProcessor (
        .iClk      (iClk),
        .rstN      (rstN),
        .videoIn   (videoIn),
        .debugCtrl (debugCtrl),
        .videoOut  (videoOut),
        .debugOut  (debugOut)
    );

    initial begin
        iClk = 1'b0;
        forever #(ClockPeriod / 2) iClk = ~iClk;
    end

    always @(posedge iClk) begin
        cycleCount <= cycleCount + 1;
        if (rstN) begin
            ticksSinceReset <= ticksSinceReset + 1;
        end
    end

    always @(posedge iClk) begin
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: tests still running after %0d cycles", TimeoutCycles);
            failRun();
        end
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic randomBits(input int count, output logic [31:0] value);
        value = '0;
        repeat (count) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic failRun();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            failRun();
        end
    endtask

    `include "tbTasks.svh"

    initial begin
        rstN      = 1'b0;
        videoIn   = '0;
        debugCtrl = '0;
        repeat (ResetCycles) @(negedge iClk);
        rstN = 1'b1;

        checkResetState();
        checkOptions();
        checkResolution();
        checkFrameRate();
        checkDebugSelect();

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== videoPkg.sv ====
package videoPkg;

    // One colour sample, r in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixelT;

    // Sync levels that travel with every pixel
    typedef struct packed {
        logic hSync;
        logic vSync;
        logic lineValid;
        logic frameValid;
    } syncT;

    // One stream beat, pixel plus syncs
    typedef struct packed {
        pixelT pixel;
        syncT  sync;
    } videoT;

    // Debug output word
    typedef logic [23:0] debugWordT;

    // Pixel operation select, bits 2..0 of the control word
    typedef logic [2:0] optionSelT;

    // Debug source select, bits 4..3 of the control word
    typedef logic [1:0] debugSelT;

    // Active width or height of a frame
    typedef logic [11:0] dimT;

    // Per-pixel operation codes
    typedef enum logic [2:0] {
        optPass      = 3'd0,
        optGray      = 3'd1,
        optInvert    = 3'd2,
        optThreshold = 3'd3,
        optRedOnly   = 3'd4,
        optSwapRB    = 3'd5,
        optHalf      = 3'd6,
        optBlack     = 3'd7
    } optionCodeT;

    // Luma level at or above which optThreshold gives white
    localparam logic [7:0] ThresholdLevel = 8'd128;

endpackage

// ==== videoStatsMeter.sv ====
`timescale 1ns/1ps

module videoStatsMeter
    import videoPkg::*;
#(
    parameter int WindowTicks = 25000000
) (
    input  logic      iClk,
    input  logic      rstN,
    input  syncT      sync,
    output debugWordT resolution,
    output debugWordT frameRate
);

    // Tick counter width, at least one bit
    localparam int TickW = (WindowTicks > 1) ? $clog2(WindowTicks) : 1;
    localparam logic [TickW-1:0] LastTick = TickW'(WindowTicks - 1);

    // Previous sync levels for edge detection
    logic lineValidDly;
    logic frameValidDly;
    logic lineFall;
    logic frameFall;

    // Running counters
    dimT              widthCnt;
    dimT              heightCnt;
    debugWordT        frameCnt;
    logic [TickW-1:0] tickCnt;
    logic             lastTick;

    // Results of the last completed line and frame
    dimT       widthReg;
    dimT       heightReg;
    debugWordT frameRateReg;

    // Falling edges, seen in the first cycle the level is low
    assign lineFall  = lineValidDly & ~sync.lineValid;
    assign frameFall = frameValidDly & ~sync.frameValid;
    assign lastTick  = (tickCnt == LastTick);

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            lineValidDly  <= 1'b0;
            frameValidDly <= 1'b0;
        end else begin
            lineValidDly  <= sync.lineValid;
            frameValidDly <= sync.frameValid;
        end
    end

    // Width counts active cycles of one line
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            widthCnt <= '0;
            widthReg <= '0;
        end else if (lineFall) begin
            widthReg <= widthCnt;
            widthCnt <= '0;
        end else if (sync.lineValid && (widthCnt != '1)) begin
            // Saturates at the largest width
            widthCnt <= widthCnt + 1'b1;
        end
    end

    // Height counts line ends inside the frame
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            heightCnt <= '0;
            heightReg <= '0;
        end else if (frameFall) begin
            heightReg <= heightCnt;
            heightCnt <= '0;
        end else if (lineFall && sync.frameValid && (heightCnt != '1)) begin
            heightCnt <= heightCnt + 1'b1;
        end
    end

    // Window timer, wraps after WindowTicks cycles
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            tickCnt <= '0;
        end else if (lastTick) begin
            tickCnt <= '0;
        end else begin
            tickCnt <= tickCnt + 1'b1;
        end
    end

    // Frame ends per window
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            frameCnt     <= '0;
            frameRateReg <= '0;
        end else if (lastTick) begin
            // A frame ending on the last tick still belongs to this window
            frameRateReg <= frameCnt + debugWordT'(frameFall);
            frameCnt     <= '0;
        end else if (frameFall) begin
            frameCnt <= frameCnt + 1'b1;
        end
    end

    // Width in the upper half, height in the lower
    assign resolution = {widthReg, heightReg};
    assign frameRate  = frameRateReg;

    // Timer never leaves its window
    tickRangeCheck: assert property (
        @(posedge iClk) disable iff (!rstN)
        int'(tickCnt) < WindowTicks
    );

    // Outside a frame the height count only holds or clears
    heightHoldCheck: assert property (
        @(posedge iClk) disable iff (!rstN)
        !sync.frameValid |=> (heightCnt == $past(heightCnt)) || (heightCnt == '0)
    );

endmodule
